// ==== compile.f ====
hw/soc_bus_pkg.sv
hw/soc_bus_router.sv
hw/soc_apb_bridge.sv
hw/soc_bus_wrap.sv
sim/soc_bus_properties.sv
sim/tb_soc_bus_wrap.sv

// ==== hw/soc_apb_bridge.sv ====
// ----------------------------
// Single 32-bit APB access per request; strobes are not forwarded
// ----------------------------
module soc_apb_bridge import soc_bus_pkg::*; (
   input  logic     clk,
   input  logic     reset_i,
   // Bus side
   input  bus_req_t req_i,
   input  logic     req_valid_i,
   output logic     req_ready_o,
   output bus_rsp_t rsp_o,
   output logic     rsp_valid_o,
   input  logic     rsp_ready_i,
   // APB side
   output apb_req_t apb_o,
   input  apb_rsp_t apb_i
);

   apb_state_e state_q;
   bus_req_t   req_q;
   bus_rsp_t   rsp_q;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         state_q <= APB_IDLE;
      end else begin
         case (state_q)
            APB_IDLE: begin
               if (req_valid_i) begin
                  state_q <= APB_SETUP;
               end
            end
            APB_SETUP: begin
               state_q <= APB_ACCESS;
            end
            APB_ACCESS: begin
               if (apb_i.pready) begin
                  state_q <= APB_RESP;
               end
            end
            APB_RESP: begin
               if (rsp_ready_i) begin
                  state_q <= APB_IDLE;
               end
            end
            default: state_q <= APB_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state_q == APB_IDLE && req_valid_i) begin
         req_q <= req_i;
      end
      if (state_q == APB_ACCESS && apb_i.pready) begin
         rsp_q.id    <= req_q.id;
         // Read word mirrored into both lanes
         rsp_q.rdata <= {apb_i.prdata, apb_i.prdata};
         rsp_q.resp  <= apb_i.pslverr ? RESP_SLVERR : RESP_OKAY;
      end
   end

   // ----------------------------
   // APB drive
   // ----------------------------
   always_comb begin
      apb_o.paddr   = req_q.addr[APB_ADDR_W-1:0];
      apb_o.pwrite  = req_q.write;
      // Address bit 2 picks the 32-bit lane
      apb_o.pwdata  = req_q.addr[2] ? req_q.wdata[DATA_W-1:APB_DATA_W]
                                    : req_q.wdata[APB_DATA_W-1:0];
      apb_o.psel    = (state_q == APB_SETUP) || (state_q == APB_ACCESS);
      apb_o.penable = (state_q == APB_ACCESS);
   end

   assign req_ready_o = (state_q == APB_IDLE);
   assign rsp_valid_o = (state_q == APB_RESP);
   assign rsp_o       = rsp_q;

endmodule

// ==== hw/soc_bus_pkg.sv ====
// ----------------------------
// Address map is fixed at compile time and regions must not overlap
// ----------------------------
package soc_bus_pkg;

   // Widths and counts
   localparam int ADDR_W     = 64;
   localparam int DATA_W     = 64;
   localparam int STRB_W     = DATA_W / 8;
   localparam int ID_W       = 4;
   localparam int APB_ADDR_W = 32;
   localparam int APB_DATA_W = 32;
   localparam int NSLV       = 6;
   localparam int NMEM       = 5;

   // ----------------------------
   // Address map
   // ----------------------------
   localparam logic [63:0] ROM_BASE    = 64'h0000_0000_0001_0000;
   localparam logic [63:0] ROM_LEN     = 64'h0000_0000_0001_0000;
   localparam logic [63:0] CLINT_BASE  = 64'h0000_0000_0200_0000;
   localparam logic [63:0] CLINT_LEN   = 64'h0000_0000_000C_0000;
   localparam logic [63:0] SLM_BASE    = 64'h0000_0000_0400_0000;
   localparam logic [63:0] SLM_LEN     = 64'h0000_0000_0400_0000;
   localparam logic [63:0] SLMDDR_BASE = 64'h0000_0000_C000_0000;
   localparam logic [63:0] SLMDDR_LEN  = 64'h0000_0000_4000_0000;
   localparam logic [63:0] DRAM_BASE   = 64'h0000_0000_8000_0000;
   localparam logic [63:0] DRAM_LEN    = 64'h0000_0000_2000_0000;
   localparam logic [63:0] APB_BASE    = 64'h0000_0000_6000_0000;
   localparam logic [63:0] APB_LEN     = 64'h0000_0000_1000_0000;

   // Memory targets sit below NMEM, APB is last
   typedef enum logic [2:0] {
      TGT_ROM    = 3'd0,
      TGT_CLINT  = 3'd1,
      TGT_SLM    = 3'd2,
      TGT_SLMDDR = 3'd3,
      TGT_DRAM   = 3'd4,
      TGT_APB    = 3'd5
   } slave_e;

   typedef enum logic [1:0] {
      RESP_OKAY   = 2'd0,
      RESP_SLVERR = 2'd2,
      RESP_DECERR = 2'd3
   } resp_e;

   typedef enum logic [1:0] {
      RT_IDLE,
      RT_REQ,
      RT_WAIT,
      RT_RESP
   } router_state_e;

   typedef enum logic [1:0] {
      APB_IDLE,
      APB_SETUP,
      APB_ACCESS,
      APB_RESP
   } apb_state_e;

   // ----------------------------
   // Bus payloads
   // ----------------------------
   typedef struct packed {
      logic [ID_W-1:0]   id;
      logic [ADDR_W-1:0] addr;
      logic              write;
      logic [DATA_W-1:0] wdata;
      logic [STRB_W-1:0] strb;
   } bus_req_t;

   typedef struct packed {
      logic [ID_W-1:0]   id;
      logic [DATA_W-1:0] rdata;
      resp_e             resp;
   } bus_rsp_t;

   typedef struct packed {
      logic [APB_ADDR_W-1:0] paddr;
      logic                  pwrite;
      logic [APB_DATA_W-1:0] pwdata;
      logic                  psel;
      logic                  penable;
   } apb_req_t;

   typedef struct packed {
      logic [APB_DATA_W-1:0] prdata;
      logic                  pready;
      logic                  pslverr;
   } apb_rsp_t;

endpackage

// ==== hw/soc_bus_router.sv ====
// ----------------------------
// One transaction in flight; initiator must hold req_i stable while valid
// ----------------------------
module soc_bus_router import soc_bus_pkg::*; (
   input  logic                  clk,
   input  logic                  reset_i,
   // Initiator side
   input  bus_req_t              req_i,
   input  logic                  req_valid_i,
   output logic                  req_ready_o,
   output bus_rsp_t              rsp_o,
   output logic                  rsp_valid_o,
   input  logic                  rsp_ready_i,
   // Target side
   output bus_req_t              tgt_req_o,
   output logic     [NSLV-1:0]   tgt_valid_o,
   input  logic     [NSLV-1:0]   tgt_ready_i,
   input  bus_rsp_t [NSLV-1:0]   tgt_rsp_i,
   input  logic     [NSLV-1:0]   tgt_rsp_valid_i,
   output logic     [NSLV-1:0]   tgt_rsp_ready_o
);

   router_state_e state_q;
   bus_req_t      req_q;
   bus_rsp_t      rsp_q;
   slave_e        tgt_q;
   slave_e        dec_tgt;
   logic          dec_hit;

   function automatic logic in_region(input logic [ADDR_W-1:0] addr,
                                      input logic [63:0]       base,
                                      input logic [63:0]       len);
      return (addr >= base) && (addr < base + len);
   endfunction

   // ----------------------------
   // Address decode
   // ----------------------------
   always_comb begin
      dec_hit = 1'b1;
      dec_tgt = TGT_ROM;
      if (in_region(req_i.addr, ROM_BASE, ROM_LEN)) begin
         dec_tgt = TGT_ROM;
      end else if (in_region(req_i.addr, CLINT_BASE, CLINT_LEN)) begin
         dec_tgt = TGT_CLINT;
      end else if (in_region(req_i.addr, SLM_BASE, SLM_LEN)) begin
         dec_tgt = TGT_SLM;
      end else if (in_region(req_i.addr, SLMDDR_BASE, SLMDDR_LEN)) begin
         dec_tgt = TGT_SLMDDR;
      end else if (in_region(req_i.addr, DRAM_BASE, DRAM_LEN)) begin
         dec_tgt = TGT_DRAM;
      end else if (in_region(req_i.addr, APB_BASE, APB_LEN)) begin
         dec_tgt = TGT_APB;
      end else begin
         dec_hit = 1'b0;
      end
   end

   // ----------------------------
   // Sequencer
   // ----------------------------
   always_ff @(posedge clk) begin
      if (reset_i) begin
         state_q <= RT_IDLE;
      end else begin
         case (state_q)
            RT_IDLE: begin
               if (req_valid_i) begin
                  state_q <= dec_hit ? RT_REQ : RT_RESP;
               end
            end
            RT_REQ: begin
               if (tgt_ready_i[tgt_q]) begin
                  state_q <= RT_WAIT;
               end
            end
            RT_WAIT: begin
               if (tgt_rsp_valid_i[tgt_q]) begin
                  state_q <= RT_RESP;
               end
            end
            RT_RESP: begin
               if (rsp_ready_i) begin
                  state_q <= RT_IDLE;
               end
            end
            default: state_q <= RT_IDLE;
         endcase
      end
   end

   // Request and response payload
   always_ff @(posedge clk) begin
      if (state_q == RT_IDLE && req_valid_i) begin
         req_q <= req_i;
         tgt_q <= dec_tgt;
         // Decode error answered locally
         rsp_q.id    <= req_i.id;
         rsp_q.rdata <= '0;
         rsp_q.resp  <= RESP_DECERR;
      end else if (state_q == RT_WAIT && tgt_rsp_valid_i[tgt_q]) begin
         rsp_q <= tgt_rsp_i[tgt_q];
      end
   end

   // ----------------------------
   // Outputs
   // ----------------------------
   always_comb begin
      tgt_valid_o     = '0;
      tgt_rsp_ready_o = '0;
      if (state_q == RT_REQ) begin
         tgt_valid_o[tgt_q] = 1'b1;
      end
      if (state_q == RT_WAIT) begin
         tgt_rsp_ready_o[tgt_q] = 1'b1;
      end
   end

   assign req_ready_o = (state_q == RT_IDLE);
   assign rsp_valid_o = (state_q == RT_RESP);
   assign rsp_o       = rsp_q;
   assign tgt_req_o   = req_q;

endmodule

// ==== hw/soc_bus_wrap.sv ====
// ----------------------------
// Memory targets share one request bus; only one valid bit is ever high
// ----------------------------
module soc_bus_wrap import soc_bus_pkg::*; (
   input  logic                  clk,
   input  logic                  reset_i,
   // Initiator port
   input  bus_req_t              req_i,
   input  logic                  req_valid_i,
   output logic                  req_ready_o,
   output bus_rsp_t              rsp_o,
   output logic                  rsp_valid_o,
   input  logic                  rsp_ready_i,
   // Memory target ports
   output bus_req_t              mem_req_o,
   output logic     [NMEM-1:0]   mem_valid_o,
   input  logic     [NMEM-1:0]   mem_ready_i,
   input  bus_rsp_t [NMEM-1:0]   mem_rsp_i,
   input  logic     [NMEM-1:0]   mem_rsp_valid_i,
   output logic     [NMEM-1:0]   mem_rsp_ready_o,
   // APB completer
   output apb_req_t              apb_o,
   input  apb_rsp_t              apb_i
);

   bus_req_t              tgt_req;
   logic     [NSLV-1:0]   tgt_valid;
   logic     [NSLV-1:0]   tgt_ready;
   bus_rsp_t [NSLV-1:0]   tgt_rsp;
   logic     [NSLV-1:0]   tgt_rsp_valid;
   logic     [NSLV-1:0]   tgt_rsp_ready;

   soc_bus_router soc_bus_router_inst (
      .clk             (clk),
      .reset_i         (reset_i),
      .req_i           (req_i),
      .req_valid_i     (req_valid_i),
      .req_ready_o     (req_ready_o),
      .rsp_o           (rsp_o),
      .rsp_valid_o     (rsp_valid_o),
      .rsp_ready_i     (rsp_ready_i),
      .tgt_req_o       (tgt_req),
      .tgt_valid_o     (tgt_valid),
      .tgt_ready_i     (tgt_ready),
      .tgt_rsp_i       (tgt_rsp),
      .tgt_rsp_valid_i (tgt_rsp_valid),
      .tgt_rsp_ready_o (tgt_rsp_ready)
   );

   soc_apb_bridge soc_apb_bridge_inst (
      .clk         (clk),
      .reset_i     (reset_i),
      .req_i       (tgt_req),
      .req_valid_i (tgt_valid[TGT_APB]),
      .req_ready_o (tgt_ready[TGT_APB]),
      .rsp_o       (tgt_rsp[TGT_APB]),
      .rsp_valid_o (tgt_rsp_valid[TGT_APB]),
      .rsp_ready_i (tgt_rsp_ready[TGT_APB]),
      .apb_o       (apb_o),
      .apb_i       (apb_i)
   );

   // Memory targets take the low indices
   assign mem_req_o                = tgt_req;
   assign mem_valid_o              = tgt_valid[NMEM-1:0];
   assign tgt_ready[NMEM-1:0]      = mem_ready_i;
   assign tgt_rsp[NMEM-1:0]        = mem_rsp_i;
   assign tgt_rsp_valid[NMEM-1:0]  = mem_rsp_valid_i;
   assign mem_rsp_ready_o          = tgt_rsp_ready[NMEM-1:0];

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_soc_bus_wrap -f compile.f -o tb_soc_bus_wrap || exit 1
./obj_dir/tb_soc_bus_wrap > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "test failed" sim.log && exit 1
grep -q "test passed" sim.log || exit 1
exit 0

// ==== sim/soc_bus_properties.sv ====
// ----------------------------
// Handshake and APB phase checks, bound to soc_bus_wrap
// ----------------------------
module soc_bus_properties import soc_bus_pkg::*; (
   input logic            clk,
   input logic            reset_i,
   input logic            req_ready_o,
   input bus_rsp_t        rsp_o,
   input logic            rsp_valid_o,
   input logic            rsp_ready_i,
   input logic [NMEM-1:0] mem_valid_o,
   input apb_req_t        apb_o
);
   timeunit 1ns;
   timeprecision 100ps;

   mem_valid_onehot: assert property (@(posedge clk) disable iff (reset_i)
      $onehot0(mem_valid_o))
      else $error("mem_valid_o has more than one bit set: %b", mem_valid_o);

   penable_needs_psel: assert property (@(posedge clk) disable iff (reset_i)
      apb_o.penable |-> apb_o.psel)
      else $error("penable high without psel");

   // Response payload frozen while the initiator stalls
   rsp_held: assert property (@(posedge clk) disable iff (reset_i)
      (rsp_valid_o && !rsp_ready_i) |=> $stable(rsp_o))
      else $error("rsp_o changed under back-pressure");

   no_accept_during_rsp: assert property (@(posedge clk) disable iff (reset_i)
      rsp_valid_o |-> !req_ready_o)
      else $error("req_ready_o high while rsp_valid_o is high");

endmodule

// ==== sim/tb_soc_bus_wrap.sv ====
// ----------------------------
// Memory targets and APB completer are models; one transaction runs at a time
// ----------------------------
module tb_soc_bus_wrap import soc_bus_pkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   // About 80 transactions of up to 30 cycles, plus reset and slack
   localparam int TXN_LIMIT  = 80;
   localparam int TXN_CYCLES = 30;
   localparam int MAX_CYCLES = TXN_LIMIT * TXN_CYCLES + 600;

   localparam logic [63:0] REGION_BASE [NSLV] = '{ROM_BASE, CLINT_BASE, SLM_BASE,
                                                  SLMDDR_BASE, DRAM_BASE, APB_BASE};
   localparam logic [63:0] REGION_LEN [NSLV]  = '{ROM_LEN, CLINT_LEN, SLM_LEN,
                                                  SLMDDR_LEN, DRAM_LEN, APB_LEN};

   logic                clk;
   logic                reset_i;
   bus_req_t            req_i;
   logic                req_valid_i;
   logic                req_ready_o;
   bus_rsp_t            rsp_o;
   logic                rsp_valid_o;
   logic                rsp_ready_i;
   bus_req_t            mem_req_o;
   logic     [NMEM-1:0] mem_valid_o;
   logic     [NMEM-1:0] mem_ready_i;
   bus_rsp_t [NMEM-1:0] mem_rsp_i;
   logic     [NMEM-1:0] mem_rsp_valid_i;
   logic     [NMEM-1:0] mem_rsp_ready_o;
   apb_req_t            apb_o;
   apb_rsp_t            apb_i;

   // Model controls and what the models saw
   int                  mem_ready_delay = 0;
   int                  mem_rsp_delay   = 0;
   resp_e               mem_resp        = RESP_OKAY;
   int                  mem_hits        = 0;
   bus_req_t            mem_seen_req;
   logic     [NMEM-1:0] mem_seen_sel;
   int                  apb_wait        = 0;
   logic     [31:0]     apb_rdata       = '0;
   logic                apb_err         = 1'b0;
   int                  apb_hits        = 0;
   apb_req_t            apb_seen;
   int                  cycle_count     = 0;

   soc_bus_wrap soc_bus_wrap_inst (.*);

   bind soc_bus_wrap soc_bus_properties soc_bus_properties_inst (
      .clk         (clk),
      .reset_i     (reset_i),
      .req_ready_o (req_ready_o),
      .rsp_o       (rsp_o),
      .rsp_valid_o (rsp_valid_o),
      .rsp_ready_i (rsp_ready_i),
      .mem_valid_o (mem_valid_o),
      .apb_o       (apb_o)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #2 clk = ~clk;
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= MAX_CYCLES) begin
         fail_now($sformatf("Timeout, the run did not finish within %0d cycles", MAX_CYCLES));
      end
   end

   task automatic fail_now(input string why);
      $display("%s", why);
      $display("test failed");
      $fatal(1, "stopped at %0t ns", $time);
   endtask

   task automatic compare_req(input string name, input bus_req_t got, input bus_req_t exp);
      if (got !== exp) begin
         fail_now($sformatf("ERR %0t ns %s got %h expected %h", $time, name, got, exp));
      end
   endtask

   task automatic compare_rsp(input string name, input bus_rsp_t got, input bus_rsp_t exp);
      if (got !== exp) begin
         fail_now($sformatf("ERR %0t ns %s got %h expected %h", $time, name, got, exp));
      end
   endtask

   task automatic compare_apb(input string name, input apb_req_t got, input apb_req_t exp);
      if (got !== exp) begin
         fail_now($sformatf("ERR %0t ns %s got %h expected %h", $time, name, got, exp));
      end
   endtask

   task automatic compare_sel(input string name, input logic [NMEM-1:0] got,
                              input logic [NMEM-1:0] exp);
      if (got !== exp) begin
         fail_now($sformatf("ERR %0t ns %s got %b expected %b", $time, name, got, exp));
      end
   endtask

   task automatic expect_latency(input int got, input int exp);
      if (got != exp) begin
         fail_now($sformatf("Response came %0d cycles after acceptance instead of %0d",
                            got, exp));
      end
   endtask

   // Read data the memory models return for an address
   function automatic logic [63:0] mem_word(input logic [63:0] addr);
      return {~addr[31:0], addr[31:0] ^ 32'h5A5A_C3C3};
   endfunction

   function automatic logic [63:0] pick_addr(input int tgt);
      logic [63:0] offs;
      offs = 64'($urandom) % REGION_LEN[tgt];
      return (REGION_BASE[tgt] + offs) & ~64'h7;
   endfunction

   // ----------------------------
   // Initiator
   // ----------------------------
   task automatic run_txn(input bus_req_t req, input int hold, output bus_rsp_t rsp,
                          output int lat);
      bus_rsp_t first;
      @(negedge clk);
      req_i       = req;
      req_valid_i = 1'b1;
      while (!req_ready_o) begin
         @(negedge clk);
      end
      // Accepted on the rising edge just passed
      @(negedge clk);
      req_valid_i = 1'b0;
      lat         = 1;
      while (!rsp_valid_o) begin
         @(negedge clk);
         lat++;
      end
      first = rsp_o;
      repeat (hold) begin
         @(negedge clk);
         compare_rsp("rsp_o", rsp_o, first);
         if (req_ready_o) begin
            fail_now("req_ready_o went high while a response was waiting");
         end
      end
      rsp_ready_i = 1'b1;
      @(negedge clk);
      rsp_ready_i = 1'b0;
      rsp         = first;
   endtask

   // ----------------------------
   // Target models
   // ----------------------------
   initial begin : mem_target_model
      int sel;
      mem_ready_i     = '0;
      mem_rsp_valid_i = '0;
      mem_rsp_i       = '0;
      forever begin
         @(negedge clk);
         if (!reset_i && mem_valid_o != '0) begin
            mem_seen_sel = mem_valid_o;
            mem_seen_req = mem_req_o;
            mem_hits++;
            sel = 0;
            for (int i = 0; i < NMEM; i++) begin
               if (mem_valid_o[i]) begin
                  sel = i;
               end
            end
            repeat (mem_ready_delay) begin
               @(negedge clk);
               compare_req("mem_req_o", mem_req_o, mem_seen_req);
               compare_sel("mem_valid_o", mem_valid_o, mem_seen_sel);
               if (req_ready_o) begin
                  fail_now("req_ready_o went high while a target request was pending");
               end
            end
            mem_ready_i[sel] = 1'b1;
            @(negedge clk);
            mem_ready_i = '0;
            repeat (mem_rsp_delay) begin
               @(negedge clk);
            end
            if (!mem_rsp_ready_o[sel]) begin
               fail_now("Router was not waiting for the memory response");
            end
            mem_rsp_i[sel].id    = mem_seen_req.id;
            mem_rsp_i[sel].rdata = mem_word(mem_seen_req.addr);
            mem_rsp_i[sel].resp  = mem_resp;
            mem_rsp_valid_i[sel] = 1'b1;
            @(negedge clk);
            mem_rsp_valid_i = '0;
            mem_rsp_i       = '0;
         end
      end
   end

   initial begin : apb_completer_model
      logic setup_seen;
      setup_seen = 1'b0;
      apb_i      = '0;
      forever begin
         @(negedge clk);
         if (apb_o.psel && !apb_o.penable) begin
            setup_seen = 1'b1;
         end else if (apb_o.psel && apb_o.penable) begin
            if (!setup_seen) begin
               fail_now("APB access phase started without a setup phase");
            end
            apb_seen = apb_o;
            apb_hits++;
            repeat (apb_wait) begin
               @(negedge clk);
               compare_apb("apb_o", apb_o, apb_seen);
            end
            apb_i.prdata  = apb_rdata;
            apb_i.pslverr = apb_err;
            apb_i.pready  = 1'b1;
            @(negedge clk);
            apb_i      = '0;
            setup_seen = 1'b0;
         end
      end
   end

   // ----------------------------
   // Directed tests
   // ----------------------------
   task automatic mem_region_access(input logic write);
      bus_req_t        req;
      bus_rsp_t        got;
      bus_rsp_t        exp;
      logic [NMEM-1:0] exp_sel;
      int              lat;
      int              hits;
      for (int round = 0; round < 2; round++) begin
         for (int t = 0; t < NMEM; t++) begin
            req.id          = 4'($urandom);
            req.addr        = pick_addr(t);
            req.write       = write;
            req.wdata       = write ? {$urandom, $urandom} : 64'h0;
            req.strb        = write ? 8'($urandom) : 8'h00;
            mem_ready_delay = (t + round) % 3;
            mem_rsp_delay   = t;
            mem_resp        = (write && round == 1) ? RESP_SLVERR : RESP_OKAY;
            exp_sel         = '0;
            exp_sel[t]      = 1'b1;
            hits            = mem_hits;
            run_txn(req, round, got, lat);
            if (mem_hits != hits + 1) begin
               fail_now($sformatf("Memory target %0d saw no request", t));
            end
            // Target valid, target response and initiator response each add a cycle
            expect_latency(lat, mem_ready_delay + mem_rsp_delay + 3);
            compare_sel("mem_valid_o", mem_seen_sel, exp_sel);
            compare_req("mem_req_o", mem_seen_req, req);
            exp.id    = req.id;
            exp.rdata = mem_word(req.addr);
            exp.resp  = mem_resp;
            compare_rsp("rsp_o", got, exp);
         end
      end
   endtask

   task automatic unmapped_access();
      logic [63:0] holes [5] = '{64'h0, 64'h0300_0000, 64'h7000_0000,
                                 64'hA000_0000, 64'h1_0000_0000};
      bus_req_t    req;
      bus_rsp_t    got;
      bus_rsp_t    exp;
      int          lat;
      int          hits;
      for (int i = 0; i < 10; i++) begin
         req.id    = 4'(i + 3);
         req.addr  = holes[i % 5] + 64'(8 * i);
         req.write = i[0];
         req.wdata = {$urandom, $urandom};
         req.strb  = 8'hFF;
         hits      = mem_hits + apb_hits;
         run_txn(req, i % 3, got, lat);
         if (mem_hits + apb_hits != hits) begin
            fail_now("An unmapped address reached a target");
         end
         if (lat != 1) begin
            fail_now($sformatf("Decode error came %0d cycles after acceptance", lat));
         end
         exp.id    = req.id;
         exp.rdata = '0;
         exp.resp  = RESP_DECERR;
         compare_rsp("rsp_o", got, exp);
      end
   endtask

   task automatic apb_access(input logic write);
      bus_req_t req;
      bus_rsp_t got;
      bus_rsp_t exp;
      apb_req_t exp_apb;
      int       lat;
      int       hits;
      for (int i = 0; i < 4; i++) begin
         req.id      = 4'($urandom);
         req.addr    = pick_addr(TGT_APB);
         req.addr[2] = i[0];
         req.write   = write;
         req.wdata   = {$urandom, $urandom};
         req.strb    = 8'hFF;
         // Reads stretch pready up to six cycles
         apb_wait    = write ? i : 2 * i;
         apb_rdata   = $urandom;
         apb_err     = write && (i == 3);
         hits        = apb_hits;
         run_txn(req, 0, got, lat);
         if (apb_hits != hits + 1) begin
            fail_now("APB completer saw no access phase");
         end
         // Setup and access phases sit between the two router handshakes
         expect_latency(lat, apb_wait + 5);
         exp_apb.paddr   = req.addr[31:0];
         exp_apb.pwrite  = write;
         exp_apb.pwdata  = req.addr[2] ? req.wdata[63:32] : req.wdata[31:0];
         exp_apb.psel    = 1'b1;
         exp_apb.penable = 1'b1;
         compare_apb("apb_o", apb_seen, exp_apb);
         exp.id    = req.id;
         exp.rdata = {apb_rdata, apb_rdata};
         exp.resp  = apb_err ? RESP_SLVERR : RESP_OKAY;
         compare_rsp("rsp_o", got, exp);
      end
   endtask

   task automatic back_pressure();
      bus_req_t req;
      bus_rsp_t got;
      bus_rsp_t exp;
      int       lat;
      // Slow SLM target, then a stalled initiator
      req.id          = 4'hA;
      req.addr        = pick_addr(TGT_SLM);
      req.write       = 1'b1;
      req.wdata       = {$urandom, $urandom};
      req.strb        = 8'h0F;
      mem_ready_delay = 6;
      mem_rsp_delay   = 4;
      mem_resp        = RESP_OKAY;
      run_txn(req, 5, got, lat);
      expect_latency(lat, mem_ready_delay + mem_rsp_delay + 3);
      compare_req("mem_req_o", mem_seen_req, req);
      exp.id    = req.id;
      exp.rdata = mem_word(req.addr);
      exp.resp  = RESP_OKAY;
      compare_rsp("rsp_o", got, exp);
      // APB read held back on both sides
      req.id    = 4'h5;
      req.addr  = pick_addr(TGT_APB);
      req.write = 1'b0;
      apb_wait  = 5;
      apb_rdata = $urandom;
      apb_err   = 1'b0;
      run_txn(req, 4, got, lat);
      expect_latency(lat, apb_wait + 5);
      exp.id    = req.id;
      exp.rdata = {apb_rdata, apb_rdata};
      exp.resp  = RESP_OKAY;
      compare_rsp("rsp_o", got, exp);
   endtask

   initial begin
      void'($urandom(32'h22bfb28e));
      reset_i     = 1'b1;
      req_i       = '0;
      req_valid_i = 1'b0;
      rsp_ready_i = 1'b0;
      repeat (8) begin
         @(posedge clk);
      end
      @(negedge clk);
      reset_i = 1'b0;
      mem_region_access(1'b0);
      mem_region_access(1'b1);
      unmapped_access();
      apb_access(1'b1);
      apb_access(1'b0);
      back_pressure();
      $display("test passed");
      $finish;
   end

endmodule
